// File: design/ahb_lite_pkg.sv
// ahb-lite bus encodings and hclk-side widths for the uart register window
package ahb_lite_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] haddr_t;  // byte address
  typedef logic [31:0] hdata_t;  // four byte lanes, lane n at bits 8n+7:8n

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // htrans
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // hsize, word is the widest the window takes
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  // hresp, ahb-lite has only these two
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

endpackage

// File: design/apb_uart_pkg.sv
// apb-side widths, uart register map and synchronizer depth
package apb_uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0] paddr_t;     // 16 byte addresses, upper half unmapped
  typedef logic [7:0] pdata_t;     // single byte lane
  typedef logic [1:0] beat_cnt_t;  // beats left after the current one

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  localparam paddr_t REG_SCRATCH = 4'd0;
  localparam paddr_t REG_CTRL    = 4'd1;
  localparam paddr_t REG_DIV_LO  = 4'd2;  // baud divisor low byte
  localparam paddr_t REG_DIV_HI  = 4'd3;
  localparam paddr_t REG_IER     = 4'd4;
  localparam paddr_t REG_STATUS  = 4'd5;  // read-only
  localparam paddr_t REG_ID      = 4'd6;  // read-only
  // 7 reserved, reads zero

  localparam pdata_t UART_ID      = 8'hA5;
  localparam pdata_t STATUS_RESET = 8'h01;  // bit 0 = transmitter empty

  // cdc
  localparam int SYNC_DEPTH = 3;

endpackage

// File: design/toggle_sync.sv
// carries a one-cycle strobe across clock domains as a toggle and back to a strobe
module toggle_sync import apb_uart_pkg::*; (
  input  logic src_clk,
  input  logic src_rstn,
  input  logic src_strb,
  input  logic dst_clk,
  input  logic dst_rstn,
  output logic dst_strb
);

  logic                  src_tgl;   // flips once per source strobe
  logic [SYNC_DEPTH-1:0] dst_sync;  // bit 0 may go metastable

  always_ff @(posedge src_clk or negedge src_rstn) begin
    if (!src_rstn) begin
      src_tgl <= 1'b0;
    end else if (src_strb) begin
      src_tgl <= ~src_tgl;
    end
  end

  always_ff @(posedge dst_clk or negedge dst_rstn) begin
    if (!dst_rstn) begin
      dst_sync <= '0;
    end else begin
      dst_sync <= {dst_sync[SYNC_DEPTH-2:0], src_tgl};
    end
  end

  assign dst_strb = dst_sync[SYNC_DEPTH-1] ^ dst_sync[SYNC_DEPTH-2];  // either edge is one event

endmodule

// File: design/ahb_slave_port.sv
// ahb-lite slave front end: accepts a transfer, hands it to the apb side and drives the response
module ahb_slave_port import ahb_lite_pkg::*; (
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       hsel,
  input  haddr_t     haddr,
  input  hdata_t     hwdata,
  input  logic       hwrite,
  input  logic [2:0] hsize,
  input  logic [1:0] htrans,
  input  logic       hready,
  input  logic       ack_strb,
  input  hdata_t     rsp_rdata,
  input  logic       rsp_err,
  output hdata_t     hrdata,
  output logic       hreadyout,
  output logic       hresp,
  output logic       req_strb,
  output haddr_t     req_addr,
  output hdata_t     req_wdata,
  output logic       req_write,
  output logic [2:0] req_size
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,   // request in flight to pclk side
    ST_ERROR   // second cycle of error response
  } state_t;

  state_t state;
  logic   xfer;         // address phase carries a real transfer
  logic   accept;
  logic   wdata_phase;  // data phase of an accepted write

  // seq handled like nonseq, no burst tracking
  always_comb begin
    case (htrans)
      HTRANS_NONSEQ, HTRANS_SEQ: xfer = 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  xfer = 1'b0;  // zero-wait okay
    endcase
  end

  assign accept = (state == ST_IDLE) && hsel && hready && xfer;

  //////////////////////////////////////////////////////////////////////
  // response fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state       <= ST_IDLE;
      hreadyout   <= 1'b1;
      hresp       <= HRESP_OKAY;
      req_strb    <= 1'b0;
      wdata_phase <= 1'b0;
    end else begin
      req_strb    <= 1'b0;  // one cycle only
      wdata_phase <= accept && hwrite;
      case (state)
        ST_IDLE: begin
          hresp <= HRESP_OKAY;  // ends second error cycle too
          if (accept) begin
            state     <= ST_WAIT;
            hreadyout <= 1'b0;  // hold master off
            req_strb  <= 1'b1;  // toggles alongside hwdata capture
          end else begin
            hreadyout <= 1'b1;
          end
        end
        ST_WAIT: begin
          if (ack_strb) begin
            if (rsp_err) begin
              state <= ST_ERROR;
              hresp <= HRESP_ERROR;  // first cycle, hreadyout stays low
            end else begin
              state     <= ST_IDLE;
              hreadyout <= 1'b1;
            end
          end
        end
        ST_ERROR: begin
          state     <= ST_IDLE;
          hreadyout <= 1'b1;  // error held for this cycle
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request capture and read data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (accept) begin
      req_addr  <= haddr;
      req_write <= hwrite;
      req_size  <= hsize;
    end
    if (wdata_phase) begin
      req_wdata <= hwdata;  // hwdata valid one cycle after address
    end
    if ((state == ST_WAIT) && ack_strb) begin
      hrdata <= rsp_rdata;  // stable on pclk side since done_strb
    end
  end

endmodule

// File: design/apb_master_port.sv
// apb master: splits a captured ahb transfer into byte beats and gathers read data by lane
module apb_master_port
  import ahb_lite_pkg::*;
  import apb_uart_pkg::*;
(
  input  logic       PCLK,
  input  logic       PRESETn,
  input  logic       start_strb,
  input  haddr_t     req_addr,
  input  hdata_t     req_wdata,
  input  logic       req_write,
  input  logic [2:0] req_size,
  input  pdata_t     prdata,
  input  logic       pready,
  input  logic       pslverr,
  output logic       psel,
  output logic       penable,
  output paddr_t     paddr,
  output logic       pwrite,
  output pdata_t     pwdata,
  output logic       done_strb,
  output hdata_t     rsp_rdata,
  output logic       rsp_err
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t     state;
  beat_cnt_t  beats_left;  // beats after the current one
  logic [1:0] lane;        // byte lane of current beat
  logic [1:0] lane_nxt;
  logic       start;
  logic       beat_end;    // access phase completes this cycle
  logic       last_beat;

  // beats minus one, so a word fits the 2-bit count
  function automatic beat_cnt_t beats_m1(input logic [2:0] size);
    case (size)
      HSIZE_WORD:  beats_m1 = 2'd3;
      HSIZE_HWORD: beats_m1 = 2'd1;
      HSIZE_BYTE:  beats_m1 = 2'd0;
      default:     beats_m1 = 2'd0;  // wider sizes not supported
    endcase
  endfunction

  assign start     = (state == ST_IDLE) && start_strb;
  assign beat_end  = (state == ST_ACCESS) && pready;
  assign lane_nxt  = lane + 2'd1;  // wraps mod 4
  assign last_beat = pslverr || (beats_left == 2'd0);  // first error stops the beats

  //////////////////////////////////////////////////////////////////////
  // beat sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state      <= ST_IDLE;
      psel       <= 1'b0;
      penable    <= 1'b0;
      done_strb  <= 1'b0;
      rsp_err    <= 1'b0;
      beats_left <= '0;
      lane       <= '0;
    end else begin
      done_strb <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state      <= ST_SETUP;
            psel       <= 1'b1;
            rsp_err    <= 1'b0;
            beats_left <= beats_m1(req_size);
            lane       <= req_addr[1:0];
          end
        end
        ST_SETUP: begin
          state   <= ST_ACCESS;
          penable <= 1'b1;
        end
        ST_ACCESS: begin
          if (beat_end) begin
            penable <= 1'b0;
            if (last_beat) begin
              state     <= ST_IDLE;
              psel      <= 1'b0;
              rsp_err   <= pslverr;
              done_strb <= 1'b1;
            end else begin
              state      <= ST_SETUP;  // back-to-back beat
              beats_left <= beats_left - 2'd1;
              lane       <= lane_nxt;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address, write data and read assembly
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (start) begin
      paddr     <= req_addr[3:0];
      pwrite    <= req_write;
      pwdata    <= req_wdata[{req_addr[1:0], 3'b000} +: 8];
      rsp_rdata <= '0;  // unread lanes stay zero
    end else if (beat_end) begin
      if (!pwrite) begin
        rsp_rdata[{lane, 3'b000} +: 8] <= prdata;
      end
      if (!last_beat) begin
        paddr  <= paddr + 4'd1;
        pwdata <= req_wdata[{lane_nxt, 3'b000} +: 8];
      end
    end
  end

endmodule

// File: design/uart_apb_regs.sv
// uart register block on apb: five writable byte registers, read-only status and id
module uart_apb_regs import apb_uart_pkg::*; (
  input  logic   PCLK,
  input  logic   PRESETn,
  input  logic   psel,
  input  logic   penable,
  input  paddr_t paddr,
  input  logic   pwrite,
  input  pdata_t pwdata,
  output pdata_t prdata,
  output logic   pready,
  output logic   pslverr
);

  pdata_t scratch;
  pdata_t ctrl;
  pdata_t div_lo;
  pdata_t div_hi;
  pdata_t ier;
  logic   wait_q;  // set on first access cycle
  logic   err;
  logic   wr_en;

  // one wait state, pready high on second access cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= psel && penable && !wait_q;
    end
  end

  assign pready = wait_q;

  // upper half unmapped, status and id not writable
  assign err     = paddr[3] || (pwrite && ((paddr == REG_STATUS) || (paddr == REG_ID)));
  assign pslverr = pready && err;
  assign wr_en   = pready && pwrite && !err;  // errored write changes nothing

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      scratch <= '0;
      ctrl    <= '0;
      div_lo  <= '0;
      div_hi  <= '0;
      ier     <= '0;
    end else if (wr_en) begin
      case (paddr)
        REG_SCRATCH: scratch <= pwdata;
        REG_CTRL:    ctrl    <= pwdata;
        REG_DIV_LO:  div_lo  <= pwdata;
        REG_DIV_HI:  div_hi  <= pwdata;
        REG_IER:     ier     <= pwdata;
        default: ;   // reserved 7 drops the write
      endcase
    end
  end

  always_comb begin
    case (paddr)
      REG_SCRATCH: prdata = scratch;
      REG_CTRL:    prdata = ctrl;
      REG_DIV_LO:  prdata = div_lo;
      REG_DIV_HI:  prdata = div_hi;
      REG_IER:     prdata = ier;
      REG_STATUS:  prdata = STATUS_RESET;  // no serializer, tx always empty
      REG_ID:      prdata = UART_ID;
      default:     prdata = '0;
    endcase
  end

endmodule

// File: design/uart_ahb_subsystem.sv
// ahb-lite window onto the uart apb registers across two clock domains
module uart_ahb_subsystem
  import ahb_lite_pkg::*;
  import apb_uart_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       HSEL,
  input  haddr_t     HADDR,
  input  hdata_t     HWDATA,
  input  logic       HWRITE,
  input  logic [2:0] HSIZE,
  input  logic [1:0] HTRANS,
  input  logic       HREADY,
  output hdata_t     HRDATA,
  output logic       HREADYOUT,
  output logic       HRESP,
  input  logic       PCLK,
  input  logic       PRESETn
);

  // hclk side request
  logic       req_strb;
  haddr_t     req_addr;
  hdata_t     req_wdata;
  logic       req_write;
  logic [2:0] req_size;
  logic       ack_strb;

  // pclk side
  logic       start_strb;
  logic       done_strb;
  hdata_t     rsp_rdata;
  logic       rsp_err;

  // apb
  logic       psel;
  logic       penable;
  paddr_t     paddr;
  logic       pwrite;
  pdata_t     pwdata;
  pdata_t     prdata;
  logic       pready;
  logic       pslverr;

  ahb_slave_port i_ahb_slave (
    .HCLK      (HCLK),      .HRESETn   (HRESETn),
    .hsel      (HSEL),      .haddr     (HADDR),
    .hwdata    (HWDATA),    .hwrite    (HWRITE),
    .hsize     (HSIZE),     .htrans    (HTRANS),
    .hready    (HREADY),    .ack_strb  (ack_strb),
    .rsp_rdata (rsp_rdata), .rsp_err   (rsp_err),
    .hrdata    (HRDATA),    .hreadyout (HREADYOUT),
    .hresp     (HRESP),     .req_strb  (req_strb),
    .req_addr  (req_addr),  .req_wdata (req_wdata),
    .req_write (req_write), .req_size  (req_size)
  );

  // hclk -> pclk
  toggle_sync req_sync (
    .src_clk (HCLK), .src_rstn (HRESETn), .src_strb (req_strb),
    .dst_clk (PCLK), .dst_rstn (PRESETn), .dst_strb (start_strb)
  );

  // pclk -> hclk
  toggle_sync ack_sync (
    .src_clk (PCLK), .src_rstn (PRESETn), .src_strb (done_strb),
    .dst_clk (HCLK), .dst_rstn (HRESETn), .dst_strb (ack_strb)
  );

  apb_master_port i_apb_master (
    .PCLK      (PCLK),      .PRESETn   (PRESETn),
    .start_strb(start_strb),.req_addr  (req_addr),
    .req_wdata (req_wdata), .req_write (req_write),
    .req_size  (req_size),  .prdata    (prdata),
    .pready    (pready),    .pslverr   (pslverr),
    .psel      (psel),      .penable   (penable),
    .paddr     (paddr),     .pwrite    (pwrite),
    .pwdata    (pwdata),    .done_strb (done_strb),
    .rsp_rdata (rsp_rdata), .rsp_err   (rsp_err)
  );

  uart_apb_regs i_regs (
    .PCLK    (PCLK),    .PRESETn (PRESETn),
    .psel    (psel),    .penable (penable),
    .paddr   (paddr),   .pwrite  (pwrite),
    .pwdata  (pwdata),  .prdata  (prdata),
    .pready  (pready),  .pslverr (pslverr)
  );

endmodule

// File: dv/uart_ahb_properties.sv
// bound protocol checks on the ahb response and the apb phases of the uart window
module uart_ahb_properties
  import ahb_lite_pkg::*;
  import apb_uart_pkg::*;
(
  input logic   HCLK,
  input logic   HRESETn,
  input logic   HREADYOUT,
  input logic   HRESP,
  input logic   PCLK,
  input logic   PRESETn,
  input logic   psel,
  input logic   penable,
  input logic   pready,
  input paddr_t paddr,
  input pdata_t pwdata
);

  int fail_cnt = 0;  // read by the testbench

  //////////////////////////////////////////////////////////////////////
  // hclk side
  //////////////////////////////////////////////////////////////////////

  // error is low-then-high hreadyout, then okay again
  a_err_two_cycles: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(HRESP == HRESP_ERROR) |->
      !HREADYOUT ##1 (HREADYOUT && (HRESP == HRESP_ERROR)) ##1 (HRESP == HRESP_OKAY))
    else begin
      $error("error response not two cycles");
      fail_cnt++;
    end

  a_ready_at_reset: assert property (@(posedge HCLK)
    $rose(HRESETn) |-> HREADYOUT && (HRESP == HRESP_OKAY))
    else begin
      $error("slave not ready with okay at reset release");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // pclk side
  //////////////////////////////////////////////////////////////////////

  // setup cycle with psel already high before every access phase
  a_setup_first: assert property (@(posedge PCLK) disable iff (!PRESETn)
    $rose(penable) |-> psel && $past(psel))
    else begin
      $error("penable rose without a setup cycle");
      fail_cnt++;
    end

  a_stable_in_wait: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (penable && !pready) |=> $stable(paddr) && $stable(pwdata))
    else begin
      $error("paddr or pwdata moved during a wait state");
      fail_cnt++;
    end

endmodule

bind uart_ahb_subsystem uart_ahb_properties i_props (
  .HCLK      (HCLK),      .HRESETn (HRESETn),
  .HREADYOUT (HREADYOUT), .HRESP   (HRESP),
  .PCLK      (PCLK),      .PRESETn (PRESETn),
  .psel      (psel),      .penable (penable),
  .pready    (pready),    .paddr   (paddr),
  .pwdata    (pwdata)
);

// File: dv/uart_ahb_tb.sv
// trace-driven testbench for the ahb-lite uart register window
module uart_ahb_tb import ahb_lite_pkg::*; ();

  localparam int          MAX_XFERS       = 64;
  localparam int          TRACE_COLS      = 6;    // words per trace line
  localparam int          CYCLES_PER_XFER = 120;
  localparam int          RESET_CYCLES    = 16;
  localparam logic [31:0] END_MARK        = 32'h0000_0fff;

  logic       HCLK;
  logic       HRESETn;
  logic       PCLK;
  logic       PRESETn;
  logic       HSEL;
  haddr_t     HADDR;
  hdata_t     HWDATA;
  logic       HWRITE;
  logic [2:0] HSIZE;
  logic [1:0] HTRANS;
  logic       HREADY;
  hdata_t     HRDATA;
  logic       HREADYOUT;
  logic       HRESP;

  logic [31:0] trace_mem [0:MAX_XFERS*TRACE_COLS-1];
  int          n_xfers;
  int          cycle_cnt;
  int          cycle_limit;   // zero until the trace is counted
  int          gap;
  integer      seed;

  uart_ahb_subsystem i_dut (
    .HCLK      (HCLK),      .HRESETn   (HRESETn),
    .HSEL      (HSEL),      .HADDR     (HADDR),
    .HWDATA    (HWDATA),    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),     .HTRANS    (HTRANS),
    .HREADY    (HREADY),    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT), .HRESP     (HRESP),
    .PCLK      (PCLK),      .PRESETn   (PRESETn)
  );

  //////////////////////////////////////////////////////////////////////
  // clocks and run limit
  //////////////////////////////////////////////////////////////////////

  always #20 HCLK = ~HCLK;  // 40 period
  always #28 PCLK = ~PCLK;  // 56 period, unrelated to hclk

  always @(posedge HCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (i_dut.i_props.fail_cnt != 0) begin
      $display("a bus protocol assertion failed, see the error above");
      $display("RESULT: FAIL");
      $fatal(1, "stopped on assertion failure");
    end else if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("transfers stalled: trace not finished after %0d HCLK cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checker and ahb master
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s got %08h expected %08h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one trace line: address phase, data phase, wait for the response
  task automatic run_xfer(input int idx);
    logic [31:0] ctl;
    logic [31:0] size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [31:0] exp_resp;
    logic        is_xfer;
    ctl       = trace_mem[idx*TRACE_COLS];
    size      = trace_mem[idx*TRACE_COLS+1];
    addr      = trace_mem[idx*TRACE_COLS+2];
    wdata     = trace_mem[idx*TRACE_COLS+3];
    exp_rdata = trace_mem[idx*TRACE_COLS+4];
    exp_resp  = trace_mem[idx*TRACE_COLS+5];
    is_xfer   = ctl[8] && ctl[5];  // selected, nonseq or seq

    @(posedge HCLK);
    HSEL   <= ctl[8];
    HTRANS <= ctl[5:4];
    HWRITE <= ctl[0];
    HSIZE  <= size[2:0];
    HADDR  <= addr;
    HREADY <= 1'b1;  // previous transfer done

    @(posedge HCLK);  // address sampled, data phase from here
    HSEL   <= 1'b0;
    HTRANS <= HTRANS_IDLE;
    HWDATA <= ctl[0] ? wdata : '0;

    @(negedge HCLK);
    // real transfers stall at once, the rest complete with no wait
    check_value({31'b0, HREADYOUT}, {31'b0, !is_xfer},
                $sformatf("hreadyout in first data cycle of line %0d", idx));
    while (!HREADYOUT) begin
      @(negedge HCLK);
    end
    check_value({31'b0, HRESP}, exp_resp, $sformatf("hresp of line %0d", idx));
    if (is_xfer && !ctl[0] && (exp_resp[0] == HRESP_OKAY)) begin
      check_value(HRDATA, exp_rdata, $sformatf("hrdata of line %0d", idx));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    HCLK        = 1'b0;
    PCLK        = 1'b0;
    HRESETn     = 1'b0;
    PRESETn     = 1'b0;
    HSEL        = 1'b0;
    HADDR       = '0;
    HWDATA      = '0;
    HWRITE      = 1'b0;
    HSIZE       = HSIZE_BYTE;
    HTRANS      = HTRANS_IDLE;
    HREADY      = 1'b1;  // single slave, never held low here
    cycle_cnt   = 0;
    cycle_limit = 0;
    seed        = 32'h7058_97cf;

    $readmemh("dv/uart_ahb_trace.txt", trace_mem);
    n_xfers = 0;
    while ((n_xfers < MAX_XFERS) && (trace_mem[n_xfers*TRACE_COLS] !== END_MARK)) begin
      n_xfers++;
    end
    if (n_xfers == MAX_XFERS) begin
      $display("trace file has no end line or is missing");
      $display("RESULT: FAIL");
      $fatal(1, "bad trace");
    end
    cycle_limit = n_xfers * CYCLES_PER_XFER + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge HCLK);
    HRESETn <= 1'b1;
    PRESETn <= 1'b1;

    for (int i = 0; i < n_xfers; i++) begin
      gap = $random(seed) & 3;  // 0 to 3 idle cycles
      repeat (gap) @(posedge HCLK);
      run_xfer(i);
    end

    repeat (4) @(posedge HCLK);  // last apb checks settle
    if (i_dut.i_props.fail_cnt != 0) begin
      $display("a bus protocol assertion failed during the run");
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: dv/uart_ahb_trace.txt
// columns: ctl hsize haddr hwdata exp_hrdata exp_hresp, all hex
// ctl digits: hsel, htrans, write (121 = selected nonseq write, 120 = read)
// byte write then read of scratch..ier, data in lane haddr mod 4
121 0 00000000 00000011 00000000 0
120 0 00000000 00000000 00000011 0
121 0 00000001 00002200 00000000 0
120 0 00000001 00000000 00002200 0
121 0 00000002 00330000 00000000 0
120 0 00000002 00000000 00330000 0
121 0 00000003 44000000 00000000 0
120 0 00000003 00000000 44000000 0
121 0 00000004 00000055 00000000 0
120 0 00000004 00000000 00000055 0
// status, id and reserved after reset
120 0 00000005 00000000 00000100 0
120 0 00000006 00000000 00a50000 0
120 0 00000007 00000000 00000000 0
120 2 00000004 00000000 00a50155 0
// word and halfword writes spread over consecutive registers
121 2 00000000 deadbeef 00000000 0
120 0 00000001 00000000 0000be00 0
120 0 00000003 00000000 de000000 0
120 2 00000000 00000000 deadbeef 0
121 1 00000002 12340000 00000000 0
120 1 00000002 00000000 12340000 0
120 2 00000000 00000000 1234beef 0
// read-only writes and unmapped accesses
121 0 00000005 0000ff00 00000000 1
120 0 00000005 00000000 00000100 0
121 0 00000006 00ff0000 00000000 1
120 0 00000006 00000000 00a50000 0
120 0 00000008 00000000 00000000 1
121 0 00000009 0000ff00 00000000 1
// word write from ier stops at the status beat
121 2 00000004 77665544 00000000 1
120 2 00000004 00000000 00a50144 0
// idle, busy and unselected transfers change nothing
101 2 00000000 ffffffff 00000000 0
111 2 00000004 ffffffff 00000000 0
021 2 00000000 ffffffff 00000000 0
120 2 00000000 00000000 1234beef 0
120 2 00000004 00000000 00a50144 0
// end of trace
fff 0 00000000 00000000 00000000 0

// File: uart_ahb.f
design/ahb_lite_pkg.sv
design/apb_uart_pkg.sv
design/toggle_sync.sv
design/ahb_slave_port.sv
design/apb_master_port.sv
design/uart_apb_regs.sv
design/uart_ahb_subsystem.sv
dv/uart_ahb_properties.sv
dv/uart_ahb_tb.sv

// File: Bender.yml
package:
  name: uart_ahb

sources:
  - design/ahb_lite_pkg.sv
  - design/apb_uart_pkg.sv
  - design/toggle_sync.sv
  - design/ahb_slave_port.sv
  - design/apb_master_port.sv
  - design/uart_apb_regs.sv
  - design/uart_ahb_subsystem.sv
  - target: simulation
    files:
      - dv/uart_ahb_properties.sv
      - dv/uart_ahb_tb.sv
